// File: branch_unit.f
+incdir+src
src/exec_pkg.sv
src/fetch_pkg.sv
src/branch_ctrl.sv
src/except_ctrl.sv
src/redirect_arbiter.sv
src/fetch_pc.sv
src/branch_unit_top.sv
tests/tb_branch_unit.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f branch_unit.f --top-module tb_branch_unit
	./obj_dir/Vtb_branch_unit > sim.log 2>&1 || echo "test failed" >> sim.log
	cat sim.log
	! grep -q "test failed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tests/tb_branch_unit.sv
// Branch unit testbench
// Reference model checked every cycle against directed and random stimulus
`timescale 1ns/1ps
`include "branch_unit_consts.svh"

module tb_branch_unit;

  localparam int RESET_CYCLES = 3;
  localparam int DIRECTED_CYCLES = 50;
  localparam int RANDOM_STEPS = 300;
  localparam int HOLD_MAX = 3;
  // Every test cycle at 10 ns plus some slack
  localparam int WATCHDOG_NS =
    (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_STEPS * HOLD_MAX) * 10 + 500;
  localparam exec_pkg::jbr_op_e OP_LIST [6] = '{exec_pkg::J, exec_pkg::JAL, exec_pkg::BNF,
                                                exec_pkg::BF, exec_pkg::JR, exec_pkg::JALR};

  // Expected outputs this cycle and model state after the next edge
  typedef struct packed {
    fetch_pkg::redirect_t      redirect;
    logic [`OPERAND_WIDTH-1:0] next_pc;
    fetch_pkg::except_cause_e  next_cause;
    logic                      next_occur;
    logic                      next_fault;
  } model_t;

  logic                      clk;
  logic                      rst;
  exec_pkg::exec_branch_t    ex_branch;
  logic                      flag;
  logic                      ext;
  logic                      ready;
  logic [`OPERAND_WIDTH-1:0] pc;
  fetch_pkg::redirect_t      redirect;
  fetch_pkg::except_cause_e  cause;

  // Model state
  logic                      occur_m;
  logic                      fault_m;
  fetch_pkg::except_cause_e  cause_m;
  logic [`OPERAND_WIDTH-1:0] pc_m;
  model_t                    expect_now;

  int err_count;
  int errs_at_start;
  int pass_tests;
  int fail_tests;

  branch_unit_top UUT (
    .clk            (clk),
    .rst            (rst),
    .ex_branch_i    (ex_branch),
    .flag_i         (flag),
    .ext_except_i   (ext),
    .fetch_ready_i  (ready),
    .pc_o           (pc),
    .redirect_o     (redirect),
    .except_cause_o (cause)
  );

  always #5 clk = ~clk;

  // Expected behavior of one cycle, straight from the redirect rules
  function automatic model_t predict_cycle(
    input exec_pkg::exec_branch_t    br,
    input logic                      flg,
    input logic                      ex,
    input logic                      rdy,
    input logic                      occur_prev,
    input logic                      fault_prev,
    input fetch_pkg::except_cause_e  cause_prev,
    input logic [`OPERAND_WIDTH-1:0] pc_now
  );
    model_t m;
    logic   reg_jump;
    logic   misaligned;
    logic   taken;
    logic   fresh_br;
    logic   fresh_fault;
    reg_jump   = (br.op == exec_pkg::JR) || (br.op == exec_pkg::JALR);
    misaligned = br.valid && reg_jump && (br.rfb[1:0] != 2'b00);
    if (br.op == exec_pkg::BF) begin
      taken = br.valid && flg;
    end else if (br.op == exec_pkg::BNF) begin
      taken = br.valid && !flg;
    end else begin
      // J and JAL always, register jumps only when aligned
      taken = br.valid && !misaligned;
    end
    m.next_occur = taken;
    m.next_fault = ex || misaligned;
    fresh_br     = taken && !occur_prev;
    fresh_fault  = m.next_fault && !fault_prev;
    m.redirect.req = fresh_br || fresh_fault;
    if (fresh_fault) begin
      m.redirect.target = ex ? `VEC_EXT : `VEC_ALIGN;
    end else begin
      m.redirect.target = reg_jump ? br.rfb : br.alu_result;
    end
    if (fresh_fault) begin
      m.next_cause = ex ? fetch_pkg::EXT : fetch_pkg::ALIGN;
    end else begin
      m.next_cause = cause_prev;
    end
    if (m.redirect.req) begin
      m.next_pc = m.redirect.target;
    end else begin
      m.next_pc = rdy ? pc_now + `INSN_STEP : pc_now;
    end
    return m;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      err_count++;
      $display("FAIL %0t %s: got %h expected %h", $time, name, actual, expected);
    end
  endtask

  // Compare on the falling edge, away from the input updates
  always @(negedge clk) begin
    if (rst) begin
      occur_m = 1'b0;
      fault_m = 1'b0;
      cause_m = fetch_pkg::NONE;
      pc_m    = `RESET_PC;
    end else begin
      expect_now = predict_cycle(ex_branch, flag, ext, ready, occur_m, fault_m, cause_m, pc_m);
      check_value("pc_o", pc, pc_m);
      check_value("redirect_o.req", 32'(redirect.req), 32'(expect_now.redirect.req));
      if (expect_now.redirect.req) begin
        check_value("redirect_o.target", redirect.target, expect_now.redirect.target);
      end
      check_value("except_cause_o", 32'(cause), 32'(cause_m));
      occur_m = expect_now.next_occur;
      fault_m = expect_now.next_fault;
      cause_m = expect_now.next_cause;
      pc_m    = expect_now.next_pc;
    end
  end

  // One execute cycle, applied on the rising edge
  task automatic drive_cycle(input logic vld, input exec_pkg::jbr_op_e op,
                             input logic [31:0] alu, input logic [31:0] rfb,
                             input logic flg, input logic ex, input logic rdy);
    @(posedge clk);
    ex_branch.valid      <= vld;
    ex_branch.op         <= op;
    ex_branch.alu_result <= alu;
    ex_branch.rfb        <= rfb;
    flag                 <= flg;
    ext                  <= ex;
    ready                <= rdy;
  endtask

  task automatic idle_cycles(input int n, input logic rdy);
    repeat (n) drive_cycle(1'b0, exec_pkg::J, 32'h0, 32'h0, 1'b0, 1'b0, rdy);
  endtask

  task automatic apply_reset();
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  endtask

  // Waits for the last cycle's compare, then tallies the test
  task automatic close_test(input string name);
    @(negedge clk);
    #1;
    if (err_count == errs_at_start) begin
      pass_tests++;
      $display("%s: ok", name);
    end else begin
      fail_tests++;
      $display("%s: %0d mismatches", name, err_count - errs_at_start);
    end
    errs_at_start = err_count;
  endtask

  task automatic run_random(input int steps);
    logic [31:0]       r;
    logic [31:0]       t;
    logic [31:0]       rfb_v;
    int                hold;
    exec_pkg::jbr_op_e op;
    for (int s = 0; s < steps; s++) begin
      r     = $urandom;
      t     = $urandom;
      op    = OP_LIST[$urandom_range(5, 0)];
      hold  = $urandom_range(HOLD_MAX, 1);
      rfb_v = {t[27:0], r[7:6], 2'b00};
      // Unaligned register target about half the time
      if (r[3]) rfb_v[1:0] = r[5:4];
      for (int h = 0; h < hold; h++) begin
        drive_cycle(r[0], op, {t[31:2], 2'b00}, rfb_v, r[8], r[11:9] == 3'd0,
                    $urandom_range(3, 0) != 0);
      end
    end
  endtask

  initial begin
    void'($urandom(32'h2276));
    err_count     = 0;
    errs_at_start = 0;
    pass_tests    = 0;
    fail_tests    = 0;
    clk           = 1'b0;
    rst           = 1'b1;
    ex_branch     = '0;
    flag          = 1'b0;
    ext           = 1'b0;
    ready         = 1'b0;
    apply_reset();

    idle_cycles(4, 1'b1);
    idle_cycles(3, 1'b0);
    idle_cycles(2, 1'b1);
    close_test("reset_and_step");

    for (int f = 0; f < 2; f++) begin
      drive_cycle(1'b1, exec_pkg::BF, 32'h1000 + 32'(f) * 32'h40, 32'h0, f[0], 1'b0, 1'b1);
      idle_cycles(1, 1'b1);
      drive_cycle(1'b1, exec_pkg::BNF, 32'h1010 + 32'(f) * 32'h40, 32'h0, f[0], 1'b0, 1'b1);
      idle_cycles(1, 1'b1);
      drive_cycle(1'b1, exec_pkg::J, 32'h1020 + 32'(f) * 32'h40, 32'h0, f[0], 1'b0, 1'b0);
      idle_cycles(1, 1'b1);
      drive_cycle(1'b1, exec_pkg::JAL, 32'h1030 + 32'(f) * 32'h40, 32'h0, f[0], 1'b0, 1'b1);
      idle_cycles(1, 1'b1);
    end
    close_test("cond_branches");

    drive_cycle(1'b1, exec_pkg::JR, 32'h0, 32'h2000, 1'b0, 1'b0, 1'b1);
    idle_cycles(1, 1'b1);
    drive_cycle(1'b1, exec_pkg::JALR, 32'h0, 32'h2400, 1'b0, 1'b0, 1'b1);
    idle_cycles(1, 1'b1);
    drive_cycle(1'b1, exec_pkg::JR, 32'h0, 32'h2002, 1'b0, 1'b0, 1'b1);
    idle_cycles(1, 1'b1);
    drive_cycle(1'b1, exec_pkg::JALR, 32'h0, 32'h2401, 1'b0, 1'b0, 1'b1);
    idle_cycles(1, 1'b1);
    close_test("reg_jumps");

    // Branch still held after the exception must not redirect
    drive_cycle(1'b1, exec_pkg::J, 32'h3000, 32'h0, 1'b0, 1'b1, 1'b1);
    drive_cycle(1'b1, exec_pkg::J, 32'h3000, 32'h0, 1'b0, 1'b0, 1'b1);
    idle_cycles(2, 1'b1);
    close_test("ext_with_branch");

    repeat (4) drive_cycle(1'b1, exec_pkg::J, 32'h4000, 32'h0, 1'b0, 1'b0, 1'b1);
    idle_cycles(3, 1'b1);
    close_test("held_branch");

    run_random(RANDOM_STEPS);
    close_test("random_mix");

    $display("tests: %0d passed, %0d failed", pass_tests, fail_tests);
    if (fail_tests == 0 && err_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
    $display("test failed");
    $finish;
  end

endmodule

// File: src/branch_unit_top.sv
// Branch unit top
// Branch and exception peers share one fetch redirect path into the PC
`timescale 1ns/1ps
`include "branch_unit_consts.svh"

module branch_unit_top (
  input  logic                      clk,
  input  logic                      rst,
  input  exec_pkg::exec_branch_t    ex_branch_i,
  input  logic                      flag_i,
  input  logic                      ext_except_i,
  input  logic                      fetch_ready_i,
  output logic [`OPERAND_WIDTH-1:0] pc_o,
  output fetch_pkg::redirect_t      redirect_o,
  output fetch_pkg::except_cause_e  except_cause_o
);

  // Peer requests toward the arbiter
  fetch_pkg::redirect_t br_req;
  fetch_pkg::redirect_t exc_req;
  // Alignment result shared with branch control
  logic                 align_fault;

  branch_ctrl u_branch_ctrl (
    .clk           (clk),
    .rst           (rst),
    .ex_branch_i   (ex_branch_i),
    .flag_i        (flag_i),
    .align_fault_i (align_fault),
    .br_req_o      (br_req)
  );

  except_ctrl u_except_ctrl (
    .clk           (clk),
    .rst           (rst),
    .ex_branch_i   (ex_branch_i),
    .ext_except_i  (ext_except_i),
    .align_fault_o (align_fault),
    .exc_req_o     (exc_req),
    .cause_o       (except_cause_o)
  );

  redirect_arbiter u_redirect_arbiter (
    .clk        (clk),
    .rst        (rst),
    .exc_req_i  (exc_req),
    .br_req_i   (br_req),
    .redirect_o (redirect_o)
  );

  // Granted redirect drives the PC
  fetch_pc u_fetch_pc (
    .clk           (clk),
    .rst           (rst),
    .redirect_i    (redirect_o),
    .fetch_ready_i (fetch_ready_i),
    .pc_o          (pc_o)
  );

endmodule

// File: src/fetch_pc.sv
// Fetch program counter
// Sequential advance with stall, redirect load has priority
`timescale 1ns/1ps
`include "branch_unit_consts.svh"

module fetch_pc (
  input  logic                      clk,
  input  logic                      rst,
  input  fetch_pkg::redirect_t      redirect_i,
  input  logic                      fetch_ready_i,
  output logic [`OPERAND_WIDTH-1:0] pc_o
);

  logic [`OPERAND_WIDTH-1:0] pc_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= `RESET_PC;
    end else if (redirect_i.req) begin
      // Redirect loads even while stalled
      pc_q <= redirect_i.target;
    end else if (fetch_ready_i) begin
      pc_q <= pc_q + `INSN_STEP;
    end
    // Otherwise hold for the stall
  end

  assign pc_o = pc_q;

  // Every fetch address is word-aligned
  a_pc_aligned : assert property (
    @(posedge clk) disable iff (rst)
    pc_o[1:0] == 2'b00
  ) else $error("fetch PC not word-aligned");

endmodule

// File: src/redirect_arbiter.sv
// Redirect arbiter
// Fixed-priority grant of the fetch redirect path, exception over branch
`timescale 1ns/1ps

module redirect_arbiter (
  input  logic                 clk,
  input  logic                 rst,
  input  fetch_pkg::redirect_t exc_req_i,
  input  fetch_pkg::redirect_t br_req_i,
  output fetch_pkg::redirect_t redirect_o
);

  logic                  grant_exc;
  logic                  grant_br;
  fetch_pkg::arb_state_e state_q;

  // Exception always wins, a losing branch is dropped
  assign grant_exc = exc_req_i.req;
  assign grant_br  = br_req_i.req && !exc_req_i.req;

  assign redirect_o.req    = grant_exc || grant_br;
  // Target is zero when nothing is granted
  assign redirect_o.target = grant_exc ? exc_req_i.target :
                             grant_br  ? br_req_i.target  : '0;

  // Last granted source
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= fetch_pkg::IDLE;
    end else if (grant_exc) begin
      state_q <= fetch_pkg::EXC_HELD;
    end else if (grant_br) begin
      state_q <= fetch_pkg::BR_HELD;
    end else begin
      state_q <= fetch_pkg::IDLE;
    end
  end

  // Branch never granted in a cycle with an exception
  a_exc_excl : assert property (
    @(posedge clk) disable iff (rst)
    (state_q == fetch_pkg::BR_HELD) |-> !$past(exc_req_i.req)
  ) else $error("branch granted alongside an exception");

endmodule

// File: src/except_ctrl.sv
// Exception control
// Flags unaligned register jumps and external requests, redirects to a vector
`timescale 1ns/1ps
`include "branch_unit_consts.svh"

module except_ctrl (
  input  logic                    clk,
  input  logic                    rst,
  input  exec_pkg::exec_branch_t  ex_branch_i,
  input  logic                    ext_except_i,
  output logic                    align_fault_o,
  output fetch_pkg::redirect_t    exc_req_o,
  output fetch_pkg::except_cause_e cause_o
);

  logic                     is_reg_jump;
  logic                     fault;
  logic                     fault_r;
  logic                     new_fault;
  fetch_pkg::except_cause_e cause_r;

  assign is_reg_jump = (ex_branch_i.op == exec_pkg::JR) ||
                       (ex_branch_i.op == exec_pkg::JALR);

  // Low two bits of the register target must be clear
  assign align_fault_o = ex_branch_i.valid && is_reg_jump &&
                         (ex_branch_i.rfb[1:0] != 2'b00);

  // Any fault source
  assign fault = ext_except_i || align_fault_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      fault_r <= 1'b0;
    end else begin
      fault_r <= fault;
    end
  end

  // Request only on the first cycle of a fault
  assign new_fault = fault && !fault_r;

  assign exc_req_o.req    = new_fault;
  // External request wins over alignment
  assign exc_req_o.target = ext_except_i ? `VEC_EXT : `VEC_ALIGN;

  // Cause held until the next fault
  always_ff @(posedge clk) begin
    if (rst) begin
      cause_r <= fetch_pkg::NONE;
    end else if (new_fault) begin
      cause_r <= ext_except_i ? fetch_pkg::EXT : fetch_pkg::ALIGN;
    end
  end

  assign cause_o = cause_r;

endmodule

// File: src/branch_ctrl.sv
// Branch control
// Resolves taken jumps and branches, one redirect per new branch
`timescale 1ns/1ps
`include "branch_unit_consts.svh"

module branch_ctrl (
  input  logic                   clk,
  input  logic                   rst,
  input  exec_pkg::exec_branch_t ex_branch_i,
  input  logic                   flag_i,
  input  logic                   align_fault_i,
  output fetch_pkg::redirect_t   br_req_o
);

  logic                      occur;
  logic                      occur_r;
  logic                      new_branch;
  logic                      is_reg_jump;
  logic [`OPERAND_WIDTH-1:0] live_target;
  logic [`OPERAND_WIDTH-1:0] target_r;

  // Taken decision, same cycle as the execute bundle
  always_comb begin
    occur = 1'b0;
    if (ex_branch_i.valid) begin
      case (ex_branch_i.op)
        exec_pkg::J,
        exec_pkg::JAL:  occur = 1'b1;
        // Conditional branches follow the flag
        exec_pkg::BF:   occur = flag_i;
        exec_pkg::BNF:  occur = !flag_i;
        // Register jumps fall to the exception side when unaligned
        exec_pkg::JR,
        exec_pkg::JALR: occur = !align_fault_i;
        default:        occur = 1'b0;
      endcase
    end
  end

  assign is_reg_jump = (ex_branch_i.op == exec_pkg::JR) ||
                       (ex_branch_i.op == exec_pkg::JALR);

  // Register target for JR/JALR, ALU result otherwise
  assign live_target = is_reg_jump ? ex_branch_i.rfb : ex_branch_i.alu_result;

  // Occur history for edge detection
  always_ff @(posedge clk) begin
    if (rst) begin
      occur_r <= 1'b0;
    end else begin
      occur_r <= occur;
    end
  end

  // First cycle of a taken branch only
  assign new_branch = occur && !occur_r;

  // Hold the target, the source operand may change next cycle
  always_ff @(posedge clk) begin
    if (new_branch) begin
      target_r <= live_target;
    end
  end

  assign br_req_o.req    = new_branch;
  // Captured target shown while the branch stays in execute
  assign br_req_o.target = new_branch ? live_target : target_r;

  // A held branch must never raise a second request
  a_single_req : assert property (
    @(posedge clk) disable iff (rst)
    br_req_o.req |=> !br_req_o.req
  ) else $error("branch request raised on consecutive cycles");

  // Held branch keeps the target captured on its first cycle
  a_target_stable : assert property (
    @(posedge clk) disable iff (rst)
    (occur && occur_r) |-> (br_req_o.target == $past(br_req_o.target))
  ) else $error("held branch target changed");

endmodule

// File: src/fetch_pkg.sv
// Fetch-side types
// Redirect request, exception cause and redirect arbiter state
`include "branch_unit_consts.svh"

package fetch_pkg;

  // One redirect request toward fetch
  typedef struct packed {
    logic                      req;
    logic [`OPERAND_WIDTH-1:0] target;
  } redirect_t;

  // Cause of the most recent exception
  typedef enum logic [1:0] {
    NONE  = 2'd0,
    ALIGN = 2'd1,
    EXT   = 2'd2
  } except_cause_e;

  // Source granted the redirect path last
  typedef enum logic [1:0] {
    IDLE     = 2'd0,
    EXC_HELD = 2'd1,
    BR_HELD  = 2'd2
  } arb_state_e;

endpackage

// File: src/exec_pkg.sv
// Execute-stage types
// Jump/branch opcodes and the branch bundle handed to branch resolution
`include "branch_unit_consts.svh"

package exec_pkg;

  // Jump/branch opcode
  // Bit 2 set on BF, clear on BNF, so the flag compare stays simple
  typedef enum logic [2:0] {
    J    = 3'b000,
    JAL  = 3'b001,
    BNF  = 3'b011,
    BF   = 3'b100,
    JR   = 3'b110,
    JALR = 3'b111
  } jbr_op_e;

  // Branch bundle from execute
  typedef struct packed {
    // Instruction in execute is a jump or branch
    logic                      valid;
    jbr_op_e                   op;
    // PC-relative target for J, JAL, BF, BNF
    logic [`OPERAND_WIDTH-1:0] alu_result;
    // Register target for JR, JALR
    logic [`OPERAND_WIDTH-1:0] rfb;
  } exec_branch_t;

endpackage

// File: src/branch_unit_consts.svh
// Branch unit constants
// Widths, reset PC, exception vectors and fetch step
`ifndef BRANCH_UNIT_CONSTS_SVH
`define BRANCH_UNIT_CONSTS_SVH

// Address and operand width
`define OPERAND_WIDTH 32

// PC value after reset
`define RESET_PC 32'h100

// Vector for an unaligned register-jump target
`define VEC_ALIGN 32'h600

// Vector for an external exception
`define VEC_EXT 32'h800

// Sequential fetch increment in bytes
`define INSN_STEP 4

`endif
